/* hw/mul_pkg.sv */
// Functional unit encodings
`default_nettype none

package mul_pkg;

    // Functional unit that an issued instruction is meant for
    typedef enum logic [1:0] {
        UNIT_ALU   = 2'd0,
        UNIT_MUL   = 2'd1,
        UNIT_OTHER = 2'd2
    } fu_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_PASS = 4'd7   // Immediate straight to the result
    } alu_op_t;

    // Low part, or high part with signedness of rs1 and rs2
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,   // MUL, MULW
        MUL_HSS = 2'd1,   // MULH
        MUL_HSU = 2'd2,   // MULHSU
        MUL_HUU = 2'd3    // MULHU
    } mul_op_t;

    // Latencies in cycles from issue to write-back
    localparam int unsigned MUL_LAT_WORD = 1;
    localparam int unsigned MUL_LAT_FULL = 2;
    localparam int unsigned ALU_LAT      = 1;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
// Core pipeline types
`default_nettype none

package core_pkg;

    // ------------------------------------------------------------------
    // Data and tag widths
    // ------------------------------------------------------------------

    // Operand or result word
    typedef logic [63:0] bus64_t;

    // Low half of an operand, used for word forms
    typedef logic [31:0] bus32_t;

    typedef logic [5:0] phreg_t;     // Physical destination register
    typedef logic [4:0] gl_index_t;  // Graduation list slot

    // ------------------------------------------------------------------
    // Issue record
    // ------------------------------------------------------------------

    // One instruction leaving register read, sent to every unit of the stage.
    // Each unit picks out its own by looking at unit
    typedef struct packed {
        logic               valid;
        mul_pkg::fu_t       unit;      // Target functional unit
        mul_pkg::alu_op_t   alu_op;
        mul_pkg::mul_op_t   mul_op;
        logic               op_32;     // Word form (W suffix)
        bus64_t             data_rs1;
        bus64_t             data_rs2;
        bus64_t             imm;
        phreg_t             prd;
        gl_index_t          gl_index;
    } issue_instr_t;

    // ------------------------------------------------------------------
    // Write-back record
    // ------------------------------------------------------------------

    // Valid for a single cycle, no handshake
    typedef struct packed {
        logic       valid;
        bus64_t     result;
        phreg_t     prd;
        gl_index_t  gl_index;
    } wb_instr_t;

endpackage

`default_nettype wire

/* hw/alu_unit.sv */
// Single-cycle integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  core_pkg::issue_instr_t instruction_i,
    output core_pkg::wb_instr_t    instruction_o
);

    logic                accept;
    core_pkg::bus64_t    rs1;
    core_pkg::bus64_t    rs2;
    core_pkg::bus64_t    sum;
    core_pkg::bus64_t    diff;
    core_pkg::bus32_t    sum_lo;
    core_pkg::bus32_t    diff_lo;
    core_pkg::bus64_t    result_d;
    core_pkg::wb_instr_t wb_d;

    assign accept = instruction_i.valid && (instruction_i.unit == mul_pkg::UNIT_ALU);

    assign rs1 = instruction_i.data_rs1;
    assign rs2 = instruction_i.data_rs2;

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------

    assign sum  = rs1 + rs2;
    assign diff = rs1 - rs2;

    // Low word of the 64-bit sum equals the sum of the low words
    assign sum_lo  = sum[31:0];
    assign diff_lo = diff[31:0];

    always_comb begin
        case (instruction_i.alu_op)
            mul_pkg::ALU_ADD: begin
                result_d = instruction_i.op_32 ? {{32{sum_lo[31]}}, sum_lo} : sum;
            end
            mul_pkg::ALU_SUB: begin
                result_d = instruction_i.op_32 ? {{32{diff_lo[31]}}, diff_lo} : diff;
            end
            mul_pkg::ALU_AND:  result_d = rs1 & rs2;
            mul_pkg::ALU_OR:   result_d = rs1 | rs2;
            mul_pkg::ALU_XOR:  result_d = rs1 ^ rs2;
            mul_pkg::ALU_SLT:  result_d = {63'd0, $signed(rs1) < $signed(rs2)};  // Full width
            mul_pkg::ALU_SLTU: result_d = {63'd0, rs1 < rs2};
            mul_pkg::ALU_PASS: result_d = instruction_i.imm;
            default:           result_d = '0;
        endcase
    end

    assign wb_d.valid    = 1'b1;
    assign wb_d.result   = result_d;
    assign wb_d.prd      = instruction_i.prd;
    assign wb_d.gl_index = instruction_i.gl_index;

    // ------------------------------------------------------------------
    // Output register, result after ALU_LAT cycles
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            instruction_o <= '0;
        end else if (flush_i || !accept) begin
            instruction_o <= '0;  // Killed or not ours
        end else begin
            instruction_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
// Pipelined integer multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,        // Kills everything in flight
    input  core_pkg::issue_instr_t instruction_i,
    output core_pkg::wb_instr_t    instruction_o
);

    typedef logic [95:0]  partial_t;   // 64 x 32 partial product
    typedef logic [127:0] product_t;   // Full 64 x 64 product

    // Control that travels down the pipe with an operation
    typedef struct packed {
        logic                valid;
        logic                neg;      // Product must be negated at the end
        mul_pkg::mul_op_t    op;
        core_pkg::phreg_t    prd;
        core_pkg::gl_index_t gl_index;
    } mul_ctrl_t;

    // Stage 0
    logic             accept;
    logic             word_d;
    logic             signed1;
    logic             signed2;
    logic             neg1;
    logic             neg2;
    core_pkg::bus32_t rs1_lo;
    core_pkg::bus32_t rs2_lo;
    core_pkg::bus64_t opa;
    core_pkg::bus64_t opb;
    core_pkg::bus64_t src1_d;
    core_pkg::bus64_t src2_d;
    mul_ctrl_t        ctrl_d;

    // Stage 1
    mul_ctrl_t        s1_ctrl_q;
    logic             s1_word_q;
    core_pkg::bus64_t s1_src1_q;
    core_pkg::bus64_t s1_src2_q;
    partial_t         low_d;
    partial_t         high_d;
    core_pkg::bus32_t word_raw;
    core_pkg::bus32_t word_res;
    core_pkg::bus64_t result_32;
    logic             word_done;

    // Stage 2
    mul_ctrl_t        s2_ctrl_q;
    partial_t         s2_low_q;
    partial_t         s2_high_q;
    product_t         product;
    product_t         product_def;
    core_pkg::bus64_t result_64;

    // ------------------------------------------------------------------
    // Stage 0: operand magnitudes and result sign
    // ------------------------------------------------------------------

    assign accept = instruction_i.valid && (instruction_i.unit == mul_pkg::UNIT_MUL);

    // Only MUL has a word form, MULH family ignores op_32
    assign word_d = instruction_i.op_32 && (instruction_i.mul_op == mul_pkg::MUL_LO);

    assign rs1_lo = instruction_i.data_rs1[31:0];
    assign rs2_lo = instruction_i.data_rs2[31:0];

    // Word operands take their sign from bit 31
    assign opa = word_d ? {{32{rs1_lo[31]}}, rs1_lo} : instruction_i.data_rs1;
    assign opb = word_d ? {{32{rs2_lo[31]}}, rs2_lo} : instruction_i.data_rs2;

    assign signed1 = (instruction_i.mul_op != mul_pkg::MUL_HUU);
    assign signed2 = (instruction_i.mul_op == mul_pkg::MUL_LO) ||
                     (instruction_i.mul_op == mul_pkg::MUL_HSS);

    assign neg1 = signed1 && opa[63];
    assign neg2 = signed2 && opb[63];

    assign src1_d = neg1 ? ~opa + 64'd1 : opa;
    assign src2_d = neg2 ? ~opb + 64'd1 : opb;

    assign ctrl_d.valid    = 1'b1;
    assign ctrl_d.neg      = neg1 ^ neg2;
    assign ctrl_d.op       = instruction_i.mul_op;
    assign ctrl_d.prd      = instruction_i.prd;
    assign ctrl_d.gl_index = instruction_i.gl_index;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_ctrl_q <= '0;
            s1_word_q <= 1'b0;
            s1_src1_q <= '0;
            s1_src2_q <= '0;
        end else if (flush_i || !accept) begin
            s1_ctrl_q <= '0;  // Bubble
            s1_word_q <= 1'b0;
            s1_src1_q <= '0;
            s1_src2_q <= '0;
        end else begin
            s1_ctrl_q <= ctrl_d;
            s1_word_q <= word_d;
            s1_src1_q <= src1_d;
            s1_src2_q <= src2_d;
        end
    end

    // ------------------------------------------------------------------
    // Stage 1: partial products, word multiply completes here
    // ------------------------------------------------------------------

    assign low_d  = s1_src1_q * s1_src2_q[31:0];
    assign high_d = s1_src1_q * s1_src2_q[63:32];

    // MULW result after MUL_LAT_WORD cycles
    assign word_raw  = low_d[31:0];
    assign word_res  = s1_ctrl_q.neg ? ~word_raw + 32'd1 : word_raw;
    assign result_32 = {{32{word_res[31]}}, word_res};
    assign word_done = s1_ctrl_q.valid && s1_word_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s2_ctrl_q <= '0;
            s2_low_q  <= '0;
            s2_high_q <= '0;
        end else if (flush_i || !s1_ctrl_q.valid || s1_word_q) begin
            s2_ctrl_q <= '0;  // Word ops already left the pipe
            s2_low_q  <= '0;
            s2_high_q <= '0;
        end else begin
            s2_ctrl_q <= s1_ctrl_q;
            s2_low_q  <= low_d;
            s2_high_q <= high_d;
        end
    end

    // ------------------------------------------------------------------
    // Stage 2: full product and part select
    // ------------------------------------------------------------------

    assign product     = {32'd0, s2_low_q} + {s2_high_q, 32'd0};
    assign product_def = s2_ctrl_q.neg ? ~product + 128'd1 : product;

    // 64-bit result after MUL_LAT_FULL cycles
    assign result_64 = (s2_ctrl_q.op == mul_pkg::MUL_LO) ? product_def[63:0]
                                                         : product_def[127:64];

    // A finishing word op wins over stage 2
    always_comb begin
        if (word_done) begin
            instruction_o.valid    = 1'b1;
            instruction_o.result   = result_32;
            instruction_o.prd      = s1_ctrl_q.prd;
            instruction_o.gl_index = s1_ctrl_q.gl_index;
        end else begin
            instruction_o.valid    = s2_ctrl_q.valid;
            instruction_o.result   = result_64;
            instruction_o.prd      = s2_ctrl_q.prd;
            instruction_o.gl_index = s2_ctrl_q.gl_index;
        end
    end

endmodule

`default_nettype wire

/* hw/exe_arith.sv */
// Integer arithmetic execute stage
`timescale 1ns/1ps
`default_nettype none

module exe_arith (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  core_pkg::issue_instr_t issue_i,   // Shared by both units
    output core_pkg::wb_instr_t    alu_wb_o,
    output core_pkg::wb_instr_t    mul_wb_o
);

    // ------------------------------------------------------------------
    // ALU, write-back one cycle after issue
    // ------------------------------------------------------------------

    alu_unit u_alu (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instruction_i (issue_i),
        .instruction_o (alu_wb_o)
    );

    // ------------------------------------------------------------------
    // Multiplier, one or two cycles depending on word form
    // ------------------------------------------------------------------

    mul_unit u_mul (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instruction_i (issue_i),
        .instruction_o (mul_wb_o)
    );

endmodule

`default_nettype wire

/* tests/exe_arith_sva.sv */
// Execute stage assertions
`timescale 1ns/1ps
`default_nettype none

module exe_arith_sva (
    input logic                   clk_i,
    input logic                   rstn_i,
    input logic                   flush_i,
    input core_pkg::issue_instr_t issue_i,
    input core_pkg::wb_instr_t    alu_wb_o,
    input core_pkg::wb_instr_t    mul_wb_o
);

    logic mul_issue;
    logic word_issue;   // MULW, done after MUL_LAT_WORD
    logic full_issue;

    assign mul_issue  = issue_i.valid && (issue_i.unit == mul_pkg::UNIT_MUL);
    assign word_issue = mul_issue && issue_i.op_32 && (issue_i.mul_op == mul_pkg::MUL_LO);
    assign full_issue = mul_issue && !word_issue;

    // ------------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------------

    reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |-> !alu_wb_o.valid && !mul_wb_o.valid)
        else $error("Write-back valid while reset is asserted");

    // Both would leave the multiplier in the same cycle
    word_after_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        full_issue |=> !word_issue)
        else $error("Word multiply issued directly after a 64-bit multiply");

    flush_clears: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !alu_wb_o.valid && !mul_wb_o.valid)
        else $error("Write-back valid in the cycle after a flush");

    mul_has_issue: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mul_wb_o.valid |-> $past(mul_issue, mul_pkg::MUL_LAT_WORD) ||
                           $past(mul_issue, mul_pkg::MUL_LAT_FULL))
        else $error("Multiplier write-back without a matching issue");

endmodule

bind exe_arith exe_arith_sva u_sva (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .flush_i  (flush_i),
    .issue_i  (issue_i),
    .alu_wb_o (alu_wb_o),
    .mul_wb_o (mul_wb_o)
);

`default_nettype wire

/* tests/tb_exe_arith.sv */
// Execute stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exe_arith;

    localparam int          MAX_CASES = 32;      // One graduation-list index per case
    localparam logic [31:0] SEED      = 32'd36;

    logic                   clk_i;
    logic                   rstn_i;
    logic                   flush_i;
    core_pkg::issue_instr_t issue_i;
    core_pkg::wb_instr_t    alu_wb_o;
    core_pkg::wb_instr_t    mul_wb_o;

    // ------------------------------------------------------------------
    // Case table and scoreboard
    // ------------------------------------------------------------------

    string            case_name   [MAX_CASES];
    int               case_unit   [MAX_CASES];
    int               case_op     [MAX_CASES];
    logic             case_w      [MAX_CASES];
    core_pkg::bus64_t case_rs1    [MAX_CASES];
    core_pkg::bus64_t case_rs2    [MAX_CASES];
    core_pkg::phreg_t case_prd    [MAX_CASES];
    logic             case_flush  [MAX_CASES];
    core_pkg::bus64_t case_result [MAX_CASES];
    int               case_due    [MAX_CASES];  // Cycle the result is expected
    int               case_strays [MAX_CASES];  // Stray count when a silent case began

    int alu_q[$];     // Case indices in issue order
    int mul_q[$];
    int silent_q[$];  // Cases that must leave no write-back

    int          n_cases      = 0;
    int          cycle        = 0;
    int          cycle_limit  = 0;
    int          pass_count   = 0;
    int          fail_count   = 0;
    int          stray_count  = 0;
    int          other_errors = 0;
    logic [31:0] rng;

    exe_arith u_dut (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .flush_i  (flush_i),
        .issue_i  (issue_i),
        .alu_wb_o (alu_wb_o),
        .mul_wb_o (mul_wb_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_word_mul(input int idx);
        return (case_unit[idx] == 1) && (case_op[idx] == 0) && case_w[idx];
    endfunction

    function automatic logic is_full_mul(input int idx);
        return (case_unit[idx] == 1) && !is_word_mul(idx);
    endfunction

    // The rs2 column is the immediate for ALU_PASS and the second operand otherwise
    // The unused field carries its complement
    function automatic core_pkg::issue_instr_t make_issue(input int idx);
        core_pkg::issue_instr_t instr;
        logic                   pass_op;
        pass_op        = (case_unit[idx] == 0) &&
                         (mul_pkg::alu_op_t'(case_op[idx]) == mul_pkg::ALU_PASS);
        instr          = '0;
        instr.valid    = 1'b1;
        instr.unit     = mul_pkg::fu_t'(case_unit[idx]);
        instr.alu_op   = mul_pkg::alu_op_t'(case_op[idx]);
        instr.mul_op   = mul_pkg::mul_op_t'(case_op[idx][1:0]);
        instr.op_32    = case_w[idx];
        instr.data_rs1 = case_rs1[idx];
        instr.data_rs2 = pass_op ? ~case_rs2[idx] : case_rs2[idx];
        instr.imm      = pass_op ? case_rs2[idx] : ~case_rs2[idx];
        instr.prd      = case_prd[idx];
        instr.gl_index = core_pkg::gl_index_t'(idx);
        return instr;
    endfunction

    function automatic core_pkg::wb_instr_t expected_wb(input int idx);
        core_pkg::wb_instr_t wb;
        wb.valid    = 1'b1;
        wb.result   = case_result[idx];
        wb.prd      = case_prd[idx];
        wb.gl_index = core_pkg::gl_index_t'(idx);
        return wb;
    endfunction

    task automatic load_cases();
        int               fd;
        int               code;
        int               fields;
        int               unit;
        int               op;
        int               w;
        int               prd;
        int               fl;
        string            line;
        string            name;
        core_pkg::bus64_t rs1;
        core_pkg::bus64_t rs2;
        core_pkg::bus64_t res;
        fd = $fopen("tests/exe_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the case file tests/exe_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %d %d %d %h %h %d %d %h",
                                     name, unit, op, w, rs1, rs2, prd, fl, res);
                    if (fields == 9 && n_cases < MAX_CASES) begin
                        case_name[n_cases]   = name;
                        case_unit[n_cases]   = unit;
                        case_op[n_cases]     = op;
                        case_w[n_cases]      = (w != 0);
                        case_rs1[n_cases]    = rs1;
                        case_rs2[n_cases]    = rs2;
                        case_prd[n_cases]    = core_pkg::phreg_t'(prd);
                        case_flush[n_cases]  = (fl != 0);
                        case_result[n_cases] = res;
                        n_cases++;
                    end else begin
                        other_errors++;
                        $display("Case line could not be read or table is full: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Queue a case on the port where its result is due
    task automatic expect_case(input int idx, input int issue_cycle);
        if (case_unit[idx] == 0) begin
            case_due[idx] = issue_cycle + mul_pkg::ALU_LAT;
            alu_q.push_back(idx);
        end else if (case_unit[idx] == 1) begin
            case_due[idx] = issue_cycle + (is_word_mul(idx) ? mul_pkg::MUL_LAT_WORD
                                                            : mul_pkg::MUL_LAT_FULL);
            mul_q.push_back(idx);
        end else begin
            case_due[idx]    = issue_cycle + mul_pkg::MUL_LAT_FULL;
            case_strays[idx] = stray_count;
            silent_q.push_back(idx);
        end
    endtask

    task automatic drop_case(input int idx, input int flush_cycle);
        case_due[idx]    = flush_cycle + mul_pkg::MUL_LAT_FULL;
        case_strays[idx] = stray_count;
        silent_q.push_back(idx);
    endtask

    // Results due after the flush cycle are killed
    task automatic purge_after(input int flush_cycle);
        int kept[$];
        int idx;
        kept = {};
        while (mul_q.size() > 0) begin
            idx = mul_q.pop_front();
            if (case_due[idx] > flush_cycle) drop_case(idx, flush_cycle);
            else kept.push_back(idx);
        end
        mul_q = kept;
        kept  = {};
        while (alu_q.size() > 0) begin
            idx = alu_q.pop_front();
            if (case_due[idx] > flush_cycle) drop_case(idx, flush_cycle);
            else kept.push_back(idx);
        end
        alu_q = kept;
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_wb(input string name, input core_pkg::wb_instr_t exp_wb,
                            input core_pkg::wb_instr_t act_wb);
        if (act_wb === exp_wb) begin
            pass_count++;
            $display("%-14s passed  result %h prd %0d gl %0d",
                     name, act_wb.result, act_wb.prd, act_wb.gl_index);
        end else begin
            fail_count++;
            $write("[ERROR] %s: expected valid %0b result %h prd %0d gl %0d,", name,
                   exp_wb.valid, exp_wb.result, exp_wb.prd, exp_wb.gl_index);
            $display(" actual valid %0b result %h prd %0d gl %0d",
                     act_wb.valid, act_wb.result, act_wb.prd, act_wb.gl_index);
        end
    endtask

    task automatic check_idle(input string port, input core_pkg::wb_instr_t act_wb);
        if (act_wb.valid !== 1'b0) begin
            stray_count++;
            $display("Unexpected write-back on the %s port in cycle %0d (prd %0d, gl %0d)",
                     port, cycle, act_wb.prd, act_wb.gl_index);
        end
    endtask

    task automatic watch_port(input logic is_alu, input core_pkg::wb_instr_t act_wb);
        int idx;
        idx = -1;
        if (is_alu && alu_q.size() > 0 && case_due[alu_q[0]] == cycle) begin
            idx = alu_q.pop_front();
        end else if (!is_alu && mul_q.size() > 0 && case_due[mul_q[0]] == cycle) begin
            idx = mul_q.pop_front();
        end
        if (idx >= 0) check_wb(case_name[idx], expected_wb(idx), act_wb);
        else check_idle(is_alu ? "ALU" : "multiplier", act_wb);
    endtask

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge clk_i) begin
        int idx;
        watch_port(1'b1, alu_wb_o);
        watch_port(1'b0, mul_wb_o);
        while (silent_q.size() > 0 && case_due[silent_q[0]] <= cycle) begin
            idx = silent_q.pop_front();
            if (stray_count == case_strays[idx]) begin
                pass_count++;
                $display("%-14s passed  no write-back", case_name[idx]);
            end else begin
                fail_count++;
                $display("%s failed: a write-back appeared where none was due",
                         case_name[idx]);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("Timeout: results still outstanding after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    initial begin
        int   gap;
        logic last_full;
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        flush_i   = 1'b0;
        issue_i   = '0;
        rng       = SEED;
        last_full = 1'b0;
        load_cases();
        cycle_limit = n_cases * 6 + 50;

        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        for (int i = 0; i < n_cases; i++) begin
            rng = xorshift32(rng);
            gap = int'(rng % 32'd3);
            if (last_full && is_word_mul(i) && gap == 0) gap = 1;  // Issue rule
            repeat (gap) begin
                @(posedge clk_i);
                issue_i <= '0;
            end
            @(posedge clk_i);
            issue_i <= make_issue(i);
            expect_case(i, cycle + 1);
            last_full = is_full_mul(i);
            if (case_flush[i]) begin
                @(posedge clk_i);
                issue_i <= '0;
                flush_i <= 1'b1;
                purge_after(cycle + 1);
                @(posedge clk_i);
                flush_i   <= 1'b0;
                last_full = 1'b0;
            end
        end
        @(posedge clk_i);
        issue_i <= '0;

        while (alu_q.size() > 0 || mul_q.size() > 0 || silent_q.size() > 0) begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);  // Catch late strays

        $display("Summary: %0d passed, %0d failed, %0d stray write-backs, %0d other errors",
                 pass_count, fail_count, stray_count, other_errors);
        if (n_cases > 0 && fail_count == 0 && stray_count == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/exe_cases.txt */
# name unit(0 alu,1 mul,2 other) op word rs1 rs2 prd flush expected
# op is the alu_op or mul_op code; rs2 also feeds the immediate; hex for operands and result
add_basic      0 0 0 0000000000000005 0000000000000007 1  0 000000000000000c
mul_small      1 0 0 0000000000000003 0000000000000005 2  0 000000000000000f
addw_wrap      0 0 1 000000007fffffff 0000000000000001 3  0 ffffffff80000000
mulh_minmin    1 1 0 8000000000000000 8000000000000000 4  0 4000000000000000
subw_neg       0 1 1 1234567800000001 0000000000000003 5  0 fffffffffffffffe
mulw_upper     1 0 1 ffffffff00000007 1234567800000003 6  0 0000000000000015
sub_full       0 1 0 0000000000000000 0000000000000001 7  0 ffffffffffffffff
mulh_neg1      1 1 0 ffffffffffffffff 0000000000000002 8  0 ffffffffffffffff
mulh_mixed     1 1 0 8000000000000000 0000000000000003 9  0 fffffffffffffffe
mulw_neg       1 0 1 00000000ffffffff abcdef0000000005 10 0 fffffffffffffffb
and_mix        0 2 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 11 0 f000f000f000f000
mulhsu_neg     1 2 0 ffffffffffffffff ffffffffffffffff 12 0 ffffffffffffffff
mul_flushed    1 0 0 0000000000000003 0000000000000007 13 1 0000000000000015
or_mix         0 3 0 f0f0f0f0f0f0f0f0 0f0f0f0f00000000 14 0 fffffffff0f0f0f0
mulhu_ones     1 3 0 ffffffffffffffff ffffffffffffffff 15 0 fffffffffffffffe
xor_mix        0 4 0 aaaaaaaaaaaaaaaa ffffffff00000000 16 0 55555555aaaaaaaa
mulhsu_pos     1 2 0 0000000000000002 8000000000000000 17 0 0000000000000001
slt_neg        0 5 0 ffffffffffffffff 0000000000000001 18 0 0000000000000001
sltu_neg       0 6 0 ffffffffffffffff 0000000000000001 19 0 0000000000000000
mulhu_zero     1 3 0 0000000000000000 ffffffffffffffff 20 0 0000000000000000
other_ignored  2 0 0 0000000000000001 0000000000000002 21 0 0000000000000000
mul_big        1 0 0 0000000100000001 0000000100000001 22 0 0000000200000001
mulw_ovf       1 0 1 0000000080000000 0000000000000002 23 0 0000000000000000
pass_imm       0 7 0 0000000000000000 00000000deadbeef 24 0 00000000deadbeef
mulhu_w        1 3 1 ffffffffffffffff 0000000000000002 25 0 0000000000000001
slt_full       0 5 1 0000000100000000 00000000ffffffff 26 0 0000000000000000
mulw_wrap      1 0 1 0000000000010000 0000000000008000 27 0 ffffffff80000000
mulh_flushed   1 1 0 0000000000000002 0000000000000003 28 1 0000000000000000
mul_neg        1 0 0 fffffffffffffffe 0000000000000003 29 0 fffffffffffffffa

/* files.f */
hw/mul_pkg.sv
hw/core_pkg.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/exe_arith.sv
tests/exe_arith_sva.sv
tests/tb_exe_arith.sv

/* Bender.yml */
package:
  name: exe_arith

sources:
  # Packages first, core_pkg uses mul_pkg
  - hw/mul_pkg.sv
  - hw/core_pkg.sv
  - hw/alu_unit.sv
  - hw/mul_unit.sv
  - hw/exe_arith.sv
  - target: test
    files:
      - tests/exe_arith_sva.sv
      - tests/tb_exe_arith.sv
